// File: common/rv_isa_pkg.sv
`default_nettype none

package rv_isa_pkg;

    // execute operations, ADD through BGEU
    typedef enum logic [3:0] {
        ADD  = 4'd0,
        SUB  = 4'd1,
        SLL  = 4'd2,
        SLT  = 4'd3,
        SLTU = 4'd4,
        XOR  = 4'd5,
        SRL  = 4'd6,
        SRA  = 4'd7,
        OR   = 4'd8,
        AND  = 4'd9,
        BEQ  = 4'd10,
        BNE  = 4'd11,
        BLT  = 4'd12,
        BGE  = 4'd13,
        BLTU = 4'd14,
        BGEU = 4'd15
    } operation_t;

    localparam logic [6:0] OPC_OP     = 7'b0110011; // register-register ops
    localparam logic [6:0] OPC_BRANCH = 7'b1100011; // conditional branches

    localparam logic [6:0] F7_BASE = 7'h00;
    localparam logic [6:0] F7_ALT  = 7'h20;         // selects SUB and SRA

    // funct3 for register-register ops
    localparam logic [2:0] F3_ADD_SUB = 3'd0;
    localparam logic [2:0] F3_SLL     = 3'd1;
    localparam logic [2:0] F3_SLT     = 3'd2;
    localparam logic [2:0] F3_SLTU    = 3'd3;
    localparam logic [2:0] F3_XOR     = 3'd4;
    localparam logic [2:0] F3_SRL_SRA = 3'd5;
    localparam logic [2:0] F3_OR      = 3'd6;
    localparam logic [2:0] F3_AND     = 3'd7;

    // branch funct3 codes 2 and 3 are reserved
    localparam logic [2:0] F3_BEQ  = 3'd0;
    localparam logic [2:0] F3_BNE  = 3'd1;
    localparam logic [2:0] F3_BLT  = 3'd4;
    localparam logic [2:0] F3_BGE  = 3'd5;
    localparam logic [2:0] F3_BLTU = 3'd6;
    localparam logic [2:0] F3_BGEU = 3'd7;

    localparam int B_IMM_W = 13;                    // branch offset incl. implied bit 0

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } r_fmt_t;

    typedef struct packed {
        logic       imm12;
        logic [5:0] imm10_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm4_1;
        logic       imm11;
        logic [6:0] opcode;
    } b_fmt_t;

    typedef union packed {
        r_fmt_t r_fmt;
        b_fmt_t b_fmt;
    } rv_instr_u;

endpackage

`default_nettype wire

// File: common/ex_pkg.sv
`default_nettype none

package ex_pkg;

    localparam int XLEN = 32;                       // data and address width
    localparam logic [XLEN-1:0] PC_STEP = 32'd4;    // no compressed instructions

    // one instruction handed to the execute stage
    typedef struct packed {
        logic                  valid;
        rv_isa_pkg::rv_instr_u instr;
        logic [XLEN-1:0]       pc;
        logic [XLEN-1:0]       rs1_val;
        logic [XLEN-1:0]       rs2_val;
    } ex_req_t;

    // registered outcome, one cycle after the request
    typedef struct packed {
        logic            valid;
        logic [XLEN-1:0] result;
        logic [XLEN-1:0] next_pc;
        logic            branch_taken;
        logic            zero_flag;
        logic            err_flag;
    } ex_resp_t;

endpackage

`default_nettype wire

// File: alu/alu_control_unit.sv
`default_nettype none
`timescale 1ns/10ps

module alu_control_unit (
    input  logic [6:0]             opcode,
    input  logic [2:0]             alu_op,           // funct3
    input  logic [6:0]             func7,
    output rv_isa_pkg::operation_t alu_control_input,
    output logic                   ctrl_err
);

    import rv_isa_pkg::*;

    logic f7_base;
    logic f7_alt;

    assign f7_base = (func7 == F7_BASE);
    assign f7_alt  = (func7 == F7_ALT);

    always_comb
    begin
        alu_control_input = ADD;
        ctrl_err          = 1'b0;
        case (opcode)
            OPC_OP:
            begin
                case (alu_op)
                    F3_ADD_SUB: alu_control_input = f7_alt ? SUB : ADD;
                    F3_SLL:     alu_control_input = SLL;
                    F3_SLT:     alu_control_input = SLT;
                    F3_SLTU:    alu_control_input = SLTU;
                    F3_XOR:     alu_control_input = XOR;
                    F3_SRL_SRA: alu_control_input = f7_alt ? SRA : SRL;
                    F3_OR:      alu_control_input = OR;
                    F3_AND:     alu_control_input = AND;
                endcase
                // only ADD/SUB and SRL/SRA accept the alternate funct7
                if (alu_op == F3_ADD_SUB || alu_op == F3_SRL_SRA)
                    ctrl_err = !(f7_base || f7_alt);
                else
                    ctrl_err = !f7_base;
            end
            OPC_BRANCH:
            begin
                case (alu_op)
                    F3_BEQ:  alu_control_input = BEQ;
                    F3_BNE:  alu_control_input = BNE;
                    F3_BLT:  alu_control_input = BLT;
                    F3_BGE:  alu_control_input = BGE;
                    F3_BLTU: alu_control_input = BLTU;
                    F3_BGEU: alu_control_input = BGEU;
                    default: ctrl_err = 1'b1;     // reserved funct3 2 and 3
                endcase
            end
            default: ctrl_err = 1'b1;             // opcode not handled here
        endcase
    end

endmodule

`default_nettype wire

// File: alu/alu.sv
`default_nettype none
`timescale 1ns/10ps

module alu (
    input  logic [6:0]               opcode,
    input  logic [2:0]               alu_op,
    input  logic [6:0]               func7,
    input  logic [ex_pkg::XLEN-1:0]  op_a,
    input  logic [ex_pkg::XLEN-1:0]  op_b,
    output logic [ex_pkg::XLEN-1:0]  alu_result,
    output logic                     zero_flag,
    output logic                     err_flag,
    output logic                     cond_jump         // branch condition holds
);

    import rv_isa_pkg::*;
    import ex_pkg::*;

    operation_t alu_control_input;
    logic       ctrl_err;
    logic       eq;
    logic       lt_signed;
    logic       lt_unsigned;
    logic [4:0] shamt;

    alu_control_unit u_ctrl (
        .opcode            (opcode),
        .alu_op            (alu_op),
        .func7             (func7),
        .alu_control_input (alu_control_input),
        .ctrl_err          (ctrl_err)
    );

    // compares shared by SLT/SLTU and the branches
    assign eq          = (op_a == op_b);
    assign lt_signed   = ($signed(op_a) < $signed(op_b));
    assign lt_unsigned = (op_a < op_b);
    assign shamt       = op_b[4:0];                 // only five bits shift on RV32

    always_comb
    begin
        alu_result = '0;
        cond_jump  = 1'b0;
        if (!ctrl_err)
        begin
            case (alu_control_input)
                ADD:  alu_result = op_a + op_b;     // carry out is dropped
                SUB:  alu_result = op_a - op_b;
                SLL:  alu_result = op_a << shamt;
                SLT:  alu_result = {{(XLEN-1){1'b0}}, lt_signed};
                SLTU: alu_result = {{(XLEN-1){1'b0}}, lt_unsigned};
                XOR:  alu_result = op_a ^ op_b;
                SRL:  alu_result = op_a >> shamt;
                SRA:  alu_result = $unsigned($signed(op_a) >>> shamt);
                OR:   alu_result = op_a | op_b;
                AND:  alu_result = op_a & op_b;
                BEQ:
                begin
                    alu_result = {XLEN{eq}};        // all ones when equal
                    cond_jump  = eq;
                end
                BNE:  cond_jump = !eq;
                BLT:  cond_jump = lt_signed;
                BGE:  cond_jump = !lt_signed;
                BLTU: cond_jump = lt_unsigned;
                BGEU: cond_jump = !lt_unsigned;
            endcase
        end
        err_flag  = ctrl_err;
        zero_flag = (alu_result == '0);
    end

endmodule

`default_nettype wire

// File: design/branch_target.sv
`default_nettype none
`timescale 1ns/10ps

module branch_target (
    input  rv_isa_pkg::rv_instr_u    instr,
    input  logic [ex_pkg::XLEN-1:0]  pc,
    output logic [ex_pkg::XLEN-1:0]  target,
    output logic                     target_misaligned
);

    import rv_isa_pkg::*;
    import ex_pkg::*;

    logic [B_IMM_W-1:0] imm_b;
    logic [XLEN-1:0]    offset;

    // immediate bits are scattered over the word and bit 0 is always zero
    assign imm_b = {instr.b_fmt.imm12,
                    instr.b_fmt.imm11,
                    instr.b_fmt.imm10_5,
                    instr.b_fmt.imm4_1,
                    1'b0};

    assign offset = {{(XLEN-B_IMM_W){imm_b[B_IMM_W-1]}}, imm_b};
    assign target = pc + offset;

    // targets must be word aligned without the C extension
    assign target_misaligned = target[1];

endmodule

`default_nettype wire

// File: design/ex_result_reg.sv
`default_nettype none
`timescale 1ns/10ps

module ex_result_reg (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     valid,
    input  logic [ex_pkg::XLEN-1:0]  pc,
    input  logic [ex_pkg::XLEN-1:0]  alu_result,
    input  logic                     zero_flag,
    input  logic                     alu_err,
    input  logic                     cond_jump,
    input  logic                     is_branch,
    input  logic [ex_pkg::XLEN-1:0]  target,
    input  logic                     target_misaligned,
    output ex_pkg::ex_resp_t         resp
);

    import ex_pkg::*;

    ex_resp_t resp_next;
    logic     take;
    logic     err;

    assign take = valid && is_branch && cond_jump;
    assign err  = valid && (alu_err || (take && target_misaligned));

    always_comb
    begin
        resp_next.valid        = valid;
        resp_next.branch_taken = take && !err;
        resp_next.err_flag     = err;
        // a faulting instruction leaves a zero result and falls through
        resp_next.result       = err ? '0 : alu_result;
        resp_next.zero_flag    = err ? 1'b1 : zero_flag;
        if (take && !err)
            resp_next.next_pc = target;
        else
            resp_next.next_pc = pc + PC_STEP;
    end

    always_ff @(posedge clk)
    begin
        if (reset)
            resp <= '0;
        else
            resp <= resp_next;                      // one cycle after the request
    end

endmodule

`default_nettype wire

// File: design/ex_stage.sv
`default_nettype none
`timescale 1ns/10ps

module ex_stage (
    input  logic             clk,
    input  logic             reset,
    input  ex_pkg::ex_req_t  req,
    output ex_pkg::ex_resp_t resp
);

    import rv_isa_pkg::*;
    import ex_pkg::*;

    logic [XLEN-1:0] alu_result;
    logic            zero_flag;
    logic            alu_err;
    logic            cond_jump;
    logic [XLEN-1:0] target;
    logic            target_misaligned;
    logic            is_branch;

    assign is_branch = (req.instr.r_fmt.opcode == OPC_BRANCH);

    // a branch shares opcode and funct3 positions with the R-type view
    alu u_alu (
        .opcode     (req.instr.r_fmt.opcode),
        .alu_op     (req.instr.r_fmt.funct3),
        .func7      (req.instr.r_fmt.funct7),
        .op_a       (req.rs1_val),
        .op_b       (req.rs2_val),
        .alu_result (alu_result),
        .zero_flag  (zero_flag),
        .err_flag   (alu_err),
        .cond_jump  (cond_jump)
    );

    branch_target u_branch_target (
        .instr             (req.instr),
        .pc                (req.pc),
        .target            (target),
        .target_misaligned (target_misaligned)
    );

    ex_result_reg u_result_reg (
        .clk               (clk),
        .reset             (reset),
        .valid             (req.valid),
        .pc                (req.pc),
        .alu_result        (alu_result),
        .zero_flag         (zero_flag),
        .alu_err           (alu_err),
        .cond_jump         (cond_jump),
        .is_branch         (is_branch),
        .target            (target),
        .target_misaligned (target_misaligned),
        .resp              (resp)
    );

endmodule

`default_nettype wire

// File: dv/ex_stage_assertions.sv
`default_nettype none
`timescale 1ns/10ps

module ex_stage_assertions (
    input logic             clk,
    input logic             reset,
    input ex_pkg::ex_req_t  req,
    input ex_pkg::ex_resp_t resp
);

    import rv_isa_pkg::*;
    import ex_pkg::*;

    localparam logic [31:0] SIGN_BIT = 32'h8000_0000;

    int       fail_count = 0;
    ex_resp_t exp_q;                                // expected response for this cycle
    logic     live_q;                               // previous cycle was out of reset

    function automatic logic [31:0] shift_right_arith(input logic [31:0] v, input logic [4:0] sh);
        logic [31:0] fill;
        fill = v[31] ? ~(32'hffff_ffff >> sh) : 32'h0;
        return (v >> sh) | fill;
    endfunction

    // ISA semantics straight from the instruction bit positions
    function automatic ex_resp_t model(input ex_req_t r);
        ex_resp_t    e;
        logic [31:0] w;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] imm;
        logic [31:0] tgt;
        logic [2:0]  f3;
        logic [6:0]  f7;
        logic        legal;
        logic        cond;
        logic        slt;
        logic        ult;
        w     = r.instr;
        a     = r.rs1_val;
        b     = r.rs2_val;
        f3    = w[14:12];
        f7    = w[31:25];
        slt   = (a ^ SIGN_BIT) < (b ^ SIGN_BIT);   // signed compare by flipping the sign
        ult   = a < b;
        imm   = {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
        tgt   = r.pc + imm;
        e     = '0;
        legal = 1'b0;
        cond  = 1'b0;
        if (w[6:0] == OPC_OP)
        begin
            legal = (f7 == 7'h00) || (f7 == 7'h20 && (f3 == 3'd0 || f3 == 3'd5));
            case (f3)
                3'd0: e.result = f7[5] ? a - b : a + b;
                3'd1: e.result = a << b[4:0];
                3'd2: e.result = {31'd0, slt};
                3'd3: e.result = {31'd0, ult};
                3'd4: e.result = a ^ b;
                3'd5: e.result = f7[5] ? shift_right_arith(a, b[4:0]) : a >> b[4:0];
                3'd6: e.result = a | b;
                3'd7: e.result = a & b;
            endcase
        end
        else if (w[6:0] == OPC_BRANCH)
        begin
            legal = (f3 != 3'd2) && (f3 != 3'd3);
            case (f3)
                3'd0:    cond = (a == b);
                3'd1:    cond = (a != b);
                3'd4:    cond = slt;
                3'd5:    cond = !slt;
                3'd6:    cond = ult;
                3'd7:    cond = !ult;
                default: cond = 1'b0;
            endcase
            e.result = (f3 == 3'd0 && a == b) ? 32'hffff_ffff : 32'h0;
        end
        e.valid        = r.valid;
        e.branch_taken = r.valid && (w[6:0] == OPC_BRANCH) && legal && cond;
        e.err_flag     = r.valid && (!legal || (e.branch_taken && tgt[1]));
        if (e.err_flag)
        begin
            e.result       = '0;
            e.branch_taken = 1'b0;
        end
        e.next_pc   = e.branch_taken ? tgt : r.pc + 32'd4;
        e.zero_flag = (e.result == '0);
        return e;
    endfunction

    task automatic note_failure(input string msg);
        $error("Error at %0t: %s", $time, msg);
        fail_count++;
    endtask

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            exp_q  <= '0;
            live_q <= 1'b0;
        end
        else
        begin
            exp_q  <= model(req);
            live_q <= 1'b1;
        end
    end

    a_reset_clear: assert property (@(posedge clk) reset |=> resp == '0)
        else note_failure("response not cleared by reset");
    a_valid: assert property (@(posedge clk) disable iff (reset)
        live_q |-> resp.valid == exp_q.valid)
        else note_failure("resp.valid does not follow the request strobe");
    a_idle_quiet: assert property (@(posedge clk) disable iff (reset)
        live_q && !exp_q.valid |-> !resp.branch_taken && !resp.err_flag)
        else note_failure("flags raised on an idle cycle");
    a_result: assert property (@(posedge clk) disable iff (reset)
        live_q && exp_q.valid |-> resp.result == exp_q.result && resp.zero_flag == exp_q.zero_flag)
        else note_failure("result or zero_flag differs from the model");
    a_next_pc: assert property (@(posedge clk) disable iff (reset)
        live_q && exp_q.valid |-> resp.next_pc == exp_q.next_pc
            && resp.branch_taken == exp_q.branch_taken)
        else note_failure("next_pc or branch_taken differs from the model");
    a_err_flag: assert property (@(posedge clk) disable iff (reset)
        live_q && exp_q.valid |-> resp.err_flag == exp_q.err_flag)
        else note_failure("err_flag differs from the model");

endmodule

`default_nettype wire

// File: dv/ex_stage_tb.sv
`default_nettype none
`timescale 1ns/10ps

module ex_stage_tb;

    import rv_isa_pkg::*;
    import ex_pkg::*;

    localparam int RESET_CYCLES = 8;
    localparam int N_PER_OP     = 20;
    localparam int N_MISALIGN   = 16;
    localparam int N_MIXED      = 64;
    localparam int N_OTHER      = 32 + 24;         // illegal encodings and idle gaps
    localparam int N_VECTORS    = RESET_CYCLES + 16 * N_PER_OP + N_MISALIGN + N_MIXED + N_OTHER;
    localparam int TIMEOUT_NS   = (N_VECTORS + 100) * 20;
    localparam logic [31:0] LFSR_TAPS = 32'h8020_0003;

    logic        clk;
    logic        reset;
    ex_req_t     req;
    ex_resp_t    resp;
    logic [31:0] lfsr_state;
    int          sent;

    ex_stage DUT (
        .clk   (clk),
        .reset (reset),
        .req   (req),
        .resp  (resp)
    );

    bind ex_stage ex_stage_assertions u_assertions (
        .clk   (clk),
        .reset (reset),
        .req   (req),
        .resp  (resp)
    );

    function automatic logic [31:0] next_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++)
        begin
            lfsr_state = (lfsr_state >> 1) ^ (lfsr_state[0] ? LFSR_TAPS : 32'h0); // galois step
            v = {v[30:0], lfsr_state[0]};
        end
        return v;
    endfunction

    function automatic logic [31:0] corner(input logic [31:0] sel);
        case (sel[1:0])
            2'd0:    return 32'h8000_0000;
            2'd1:    return 32'h7fff_ffff;
            2'd2:    return 32'hffff_ffff;
            default: return 32'h0000_0000;
        endcase
    endfunction

    function automatic logic [31:0] encode_r(input logic [6:0] f7, input logic [2:0] f3,
                                             input logic [6:0] opc);
        return {f7, 5'd9, 5'd8, f3, 5'd4, opc};
    endfunction

    function automatic logic [31:0] encode_b(input logic [12:0] imm, input logic [2:0] f3);
        return {imm[12], imm[10:5], 5'd9, 5'd8, f3, imm[4:1], imm[11], OPC_BRANCH};
    endfunction

    function automatic logic [12:0] branch_imm(input logic [1:0] low);
        logic [31:0] tmp;
        tmp = next_bits(11);
        return {tmp[10:0], low};                    // low 2'b10 makes the target misaligned
    endfunction

    function automatic logic [31:0] r_type_word(input int k);
        case (k)
            0:       return encode_r(F7_BASE, F3_ADD_SUB, OPC_OP);
            1:       return encode_r(F7_ALT, F3_ADD_SUB, OPC_OP);
            2:       return encode_r(F7_BASE, F3_SLL, OPC_OP);
            3:       return encode_r(F7_BASE, F3_SLT, OPC_OP);
            4:       return encode_r(F7_BASE, F3_SLTU, OPC_OP);
            5:       return encode_r(F7_BASE, F3_XOR, OPC_OP);
            6:       return encode_r(F7_BASE, F3_SRL_SRA, OPC_OP);
            7:       return encode_r(F7_ALT, F3_SRL_SRA, OPC_OP);
            8:       return encode_r(F7_BASE, F3_OR, OPC_OP);
            default: return encode_r(F7_BASE, F3_AND, OPC_OP);
        endcase
    endfunction

    function automatic logic [2:0] branch_f3(input int k);
        case (k)
            0:       return F3_BEQ;
            1:       return F3_BNE;
            2:       return F3_BLT;
            3:       return F3_BGE;
            4:       return F3_BLTU;
            default: return F3_BGEU;
        endcase
    endfunction

    // called right after a rising edge and returns on the next one
    task automatic issue(input logic v, input logic [31:0] w, input logic [31:0] pc,
                         input logic [31:0] a, input logic [31:0] b);
        ex_req_t r;
        r.valid   = v;
        r.instr   = w;
        r.pc      = pc;
        r.rs1_val = a;
        r.rs2_val = b;
        req <= r;
        sent++;
        @(posedge clk);
    endtask

    task automatic send_random(input logic v, input logic [31:0] w);
        logic [31:0] mode;
        logic [31:0] a;
        logic [31:0] b;
        mode = next_bits(3);
        a    = next_bits(32);
        b    = next_bits(32);
        case (mode)
            32'd0, 32'd1: b = a;                    // equal operands
            32'd2:        a = corner(next_bits(2));
            32'd3:
            begin
                a = corner(next_bits(2));
                b = corner(next_bits(2));
            end
            default: ;
        endcase
        issue(v, w, next_bits(30) << 2, a, b);
    endtask

    task automatic idle(input int n);
        for (int i = 0; i < n; i++)
            send_random(1'b0, next_bits(32));
    endtask

    task automatic misaligned_tests;
        logic [31:0] a;
        for (int j = 0; j < N_MISALIGN; j++)
        begin
            a = next_bits(32);
            // beq taken faults while bne with equal operands falls through cleanly
            issue(1'b1, encode_b(branch_imm(2'b10), j[0] ? F3_BNE : F3_BEQ),
                  next_bits(30) << 2, a, a);
        end
    endtask

    task automatic illegal_tests;
        logic [31:0] tmp;
        logic [6:0]  opc;
        for (int j = 0; j < 8; j++)
        begin
            tmp = next_bits(10);
            opc = tmp[6:0];
            if (opc == OPC_OP || opc == OPC_BRANCH)
                opc = 7'b0010011;                   // op-imm lies outside this stage
            send_random(1'b1, encode_r(F7_BASE, tmp[9:7], opc));
            send_random(1'b1, encode_r(7'h01, 3'(j), OPC_OP));
            if (j != 0 && j != 5)
                send_random(1'b1, encode_r(F7_ALT, 3'(j), OPC_OP));
            send_random(1'b1, encode_b(branch_imm(2'b00), j[0] ? 3'd3 : 3'd2));
        end
    endtask

    initial
    begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    initial
    begin
        #(TIMEOUT_NS);
        $display("timeout: the testbench did not reach its end in %0d ns", TIMEOUT_NS);
        $display("FAIL: see errors above");
        $finish;
    end

    initial
    begin
        logic [31:0] sel;
        lfsr_state = 32'had27b6b0;
        sent       = 0;
        reset      = 1'b1;
        req        = '0;
        @(posedge clk);
        for (int i = 0; i < RESET_CYCLES - 1; i++)
            issue(1'b1, encode_b(13'd8, F3_BEQ), 32'h100, 32'h5, 32'h5); // taken if not held
        reset <= 1'b0;
        for (int k = 0; k < 10; k++)
            for (int j = 0; j < N_PER_OP; j++)
                send_random(1'b1, r_type_word(k));
        idle(3);
        for (int k = 0; k < 6; k++)
            for (int j = 0; j < N_PER_OP; j++)
                send_random(1'b1, encode_b(branch_imm(2'b00), branch_f3(k)));
        idle(3);
        misaligned_tests();
        idle(3);
        illegal_tests();
        idle(3);
        for (int j = 0; j < N_MIXED; j++)
        begin
            sel = next_bits(4);
            if (sel < 10)
                send_random(next_bits(1) != 0, r_type_word(sel));
            else
                send_random(next_bits(1) != 0, encode_b(branch_imm(2'b00), branch_f3(sel - 10)));
        end
        idle(3);                                    // let the last response be checked
        $display("closing report: %0d vectors, %0d assertion failures",
                 sent, DUT.u_assertions.fail_count);
        if (DUT.u_assertions.fail_count == 0)
            $display("PASS: all tests");
        else
            $display("FAIL: see errors above");
        $finish;
    end

endmodule

`default_nettype wire

// File: project.f
common/rv_isa_pkg.sv
common/ex_pkg.sv
alu/alu_control_unit.sv
alu/alu.sv
design/branch_target.sv
design/ex_result_reg.sv
design/ex_stage.sv
dv/ex_stage_assertions.sv
dv/ex_stage_tb.sv

// File: Makefile
TOP := ex_stage_tb

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list these targets"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the Verilator build directory"

test:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f project.f
	@out=$$(./obj_dir/V$(TOP) +verilator+error+limit+100000); \
	echo "$$out"; \
	echo "$$out" | grep -q "PASS: all tests"

clean:
	rm -rf obj_dir
